//--- Makefile
VERILATOR ?= verilator
TOP       ?= drive_logic_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/drive_bus_decode.sv
`timescale 1ns/1ps

module drive_bus_decode
(
	input  drive_pkg::drv_mode_t drv_mode_i,
	input  drive_pkg::cpu_addr_t addr_i,
	input  logic                 rw_i,         // 1 read
	input  drive_pkg::cpu_data_t ram_rdata_i,
	input  drive_pkg::cpu_data_t port1_rdata_i,
	input  drive_pkg::cpu_data_t port2_rdata_i,
	input  drive_pkg::cpu_data_t rom_data_i,
	output logic                 ram_cs_o,
	output logic                 port1_cs_o,
	output logic                 port2_cs_o,
	output drive_pkg::cpu_data_t rdata_o
);
	import drive_pkg::*;

	logic [3:0] ls42_idx;   // index of the 1541 decoder chip
	logic       io_block;   // $1xxx on the newer boards
	logic       rom_cs;

	assign ls42_idx = {addr_i[15], addr_i[12:10]};
	assign io_block = addr_i[15:12] == 4'h1;
	assign rom_cs   = addr_i[15];

	// ------------------------------------------------------------
	// chip selects
	// ------------------------------------------------------------
	always_comb
	begin
		if (drv_mode_i == MODE_1541)
		begin
			ram_cs_o   = (ls42_idx == 4'd0) || (ls42_idx == 4'd1);
			port1_cs_o = ls42_idx == 4'd6;   // $1800
			port2_cs_o = ls42_idx == 4'd7;   // $1C00
		end
		else
		begin
			// 2 KB mirrored in $0xxx and $6000-$7FFF
			ram_cs_o   = (addr_i[15:12] == 4'h0) || (addr_i[15:13] == 3'b011);
			port1_cs_o = io_block && !addr_i[10];
			port2_cs_o = io_block && addr_i[10];
		end
	end

	// ------------------------------------------------------------
	// read data, priority ram > port1 > port2 > rom
	// ------------------------------------------------------------
	always_comb
	begin
		if (!rw_i)
			rdata_o = '1;
		else if (ram_cs_o)
			rdata_o = ram_rdata_i;
		else if (port1_cs_o)
			rdata_o = port1_rdata_i;
		else if (port2_cs_o)
			rdata_o = port2_rdata_i;
		else if (rom_cs)
			rdata_o = rom_data_i;
		else
			rdata_o = '1;   // open bus
	end

endmodule

//--- design/drive_clock_ctrl.sv
`timescale 1ns/1ps

module drive_clock_ctrl
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  drive_pkg::drv_mode_t drv_mode_i,
	input  logic                 accl_i,     // 1 selects the 2 MHz strobes
	input  logic [1:0]           ph2_r_i,    // [0] 1 MHz, [1] 2 MHz
	input  logic [1:0]           ph2_f_i,
	output logic                 ena_r_o,
	output logic                 ena_f_o
);
	import drive_pkg::*;

	logic [2:0] speed_q;    // speed select history
	logic       speed_sel;
	logic       halt;

	// ------------------------------------------------------------
	// speed history
	// ------------------------------------------------------------
	assign speed_sel = speed_q[1];
	assign halt      = speed_q[0] ^ speed_q[2];   // switch in progress

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			speed_q <= 3'b000;
		else if (drv_mode_i == MODE_1541)
			speed_q <= 3'b000;   // 1541 has no fast mode
		else if (ph2_r_i[speed_sel])
			speed_q <= {speed_q[1:0], accl_i};
	end

	// ------------------------------------------------------------
	// cpu enables
	// ------------------------------------------------------------
	// same clock as the strobe, nothing while the speed settles
	assign ena_f_o = ph2_f_i[speed_sel] & ~halt;
	assign ena_r_o = ph2_r_i[speed_sel] & ~halt;

endmodule

//--- design/drive_gcr_head.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

module drive_gcr_head
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 hclk_i,     // one clk per bit cell
	input  logic                 hf_i,
	input  logic                 mode_i,     // 1 read, 0 write
	input  logic                 soe_i,      // byte strobe enable
	input  drive_pkg::cpu_data_t wbyte_i,
	output drive_pkg::cpu_data_t rbyte_o,
	output logic                 sync_n_o,
	output logic                 byte_n_o,
	output logic                 ht_o
);
	import drive_pkg::*;

	gcr_state_t                state_q;
	logic [`DRV_SYNC_ONES-2:0] shift_q;
	logic [`DRV_SYNC_ONES-1:0] shift_nx;   // window including the new bit
	logic [2:0]                bit_cnt_q;
	logic                      byte_done;
	cpu_data_t                 wshift_q;

	assign shift_nx = {shift_q, hf_i};

	// 8th bit of a byte, in read mode only after a sync
	assign byte_done = hclk_i && (bit_cnt_q == 3'd7) && (!mode_i || (state_q == BYTES));

	assign sync_n_o = state_q != SYNC;
	assign ht_o     = wshift_q[7];

	// ------------------------------------------------------------
	// read sequencer
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			state_q <= HUNT;
		else if (!mode_i)
			state_q <= HUNT;
		else if (hclk_i)
		begin
			case (state_q)
				HUNT, BYTES: if (&shift_nx) state_q <= SYNC;
				SYNC:        if (!hf_i) state_q <= BYTES;    // zero ends the mark
				default:     state_q <= HUNT;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			shift_q   <= '0;
			bit_cnt_q <= '0;
		end
		else if (hclk_i)
		begin
			shift_q <= shift_nx[`DRV_SYNC_ONES-2:0];
			if (mode_i && (state_q == SYNC))
				bit_cnt_q <= '0;   // byte framing restarts at the mark
			else
				bit_cnt_q <= bit_cnt_q + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (byte_done && mode_i)
			rbyte_o <= shift_nx[7:0];
	end

	// byte ready strobe, one clk low
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			byte_n_o <= 1'b1;
		else
			byte_n_o <= !(byte_done && soe_i);
	end

	// ------------------------------------------------------------
	// write serializer, msb first
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			wshift_q <= '0;
		else if (hclk_i && !mode_i)
			wshift_q <= byte_done ? wbyte_i : {wshift_q[6:0], 1'b0};
	end

endmodule

//--- design/drive_logic_top.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

module drive_logic_top
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  drive_pkg::drv_mode_t drv_mode_i,
	input  logic [1:0]           ph2_r_i,
	input  logic [1:0]           ph2_f_i,
	output logic                 cycle_start_o,
	output logic                 cycle_mid_o,
	input  drive_pkg::cpu_addr_t bus_addr_i,
	input  logic                 bus_rw_i,
	input  drive_pkg::cpu_data_t bus_wdata_i,
	output drive_pkg::cpu_data_t bus_rdata_o,
	output logic [14:0]          rom_addr_o,
	input  drive_pkg::cpu_data_t rom_data_i,
	input  logic                 iec_atn_i,
	input  logic                 iec_clk_i,
	input  logic                 iec_data_i,
	output logic                 iec_clk_o,
	output logic                 iec_data_o,
	input  logic                 wps_n_i,
	input  logic                 tr00_n_i,
	input  logic                 hclk_i,
	input  logic                 hf_i,
	output logic                 ht_o,
	output logic                 side_o,
	output logic                 mode_o,
	output logic [1:0]           stp_o,
	output logic                 mtr_o,
	output logic                 act_o,
	output logic [1:0]           freq_o,
	output logic                 irq_n_o
);
	import drive_pkg::*;

	logic      accl;
	logic      ram_cs;
	logic      port1_cs;
	logic      port2_cs;
	logic      port1_irq;
	logic      port2_irq;
	logic      soe;
	logic      sync_n;
	logic      byte_n;
	cpu_data_t ram_rdata;
	cpu_data_t port1_rdata;
	cpu_data_t port2_rdata;
	cpu_data_t p1_pa;
	cpu_data_t p1_pb;
	cpu_data_t p2_pa;
	cpu_data_t p2_pb;
	cpu_data_t head_byte;

	// ------------------------------------------------------------
	// clocking, decode and ram
	// ------------------------------------------------------------
	drive_clock_ctrl u_clock_ctrl (.clk(clk), .rst_n_i(rst_n_i), .drv_mode_i(drv_mode_i),
		.accl_i(accl), .ph2_r_i(ph2_r_i), .ph2_f_i(ph2_f_i),
		.ena_r_o(cycle_mid_o), .ena_f_o(cycle_start_o));

	drive_bus_decode u_bus_decode (.drv_mode_i(drv_mode_i), .addr_i(bus_addr_i),
		.rw_i(bus_rw_i), .ram_rdata_i(ram_rdata), .port1_rdata_i(port1_rdata),
		.port2_rdata_i(port2_rdata), .rom_data_i(rom_data_i), .ram_cs_o(ram_cs),
		.port1_cs_o(port1_cs), .port2_cs_o(port2_cs), .rdata_o(bus_rdata_o));

	drive_ram u_ram (.clk(clk), .we_i(cycle_mid_o & ~bus_rw_i & ram_cs),
		.addr_i(bus_addr_i[`DRV_RAM_AW-1:0]), .wdata_i(bus_wdata_i), .rdata_o(ram_rdata));

	assign rom_addr_o = bus_addr_i[14:0];

	// ------------------------------------------------------------
	// port 1, serial bus and speed select
	// ------------------------------------------------------------
	drive_port_unit port1 (.clk(clk), .rst_n_i(rst_n_i), .ena_r_i(cycle_mid_o),
		.cs_i(port1_cs), .rw_i(bus_rw_i), .reg_i(bus_addr_i[3:0]), .wdata_i(bus_wdata_i),
		.rdata_o(port1_rdata),
		.pa_i({byte_n | (drv_mode_i == MODE_1541), 6'h3F, tr00_n_i}), .pa_o(p1_pa),
		.pb_i({~iec_atn_i, 2'b00, 2'b11, ~iec_clk_i, 1'b1, ~iec_data_i}), // drive 8
		.pb_o(p1_pb), .ca1_i(~iec_atn_i), .ca2_o(), .cb2_o(), .irq_o(port1_irq));

	assign accl       = p1_pa[5] & (drv_mode_i != MODE_1541);
	assign side_o     = p1_pa[2] & (drv_mode_i == MODE_1571);
	assign iec_clk_o  = ~p1_pb[3];
	assign iec_data_o = ~p1_pb[1] & ~(p1_pb[4] ^ ~iec_atn_i);   // atn acknowledge

	// ------------------------------------------------------------
	// port 2, mechanics and head
	// ------------------------------------------------------------
	drive_port_unit port2 (.clk(clk), .rst_n_i(rst_n_i), .ena_r_i(cycle_mid_o),
		.cs_i(port2_cs), .rw_i(bus_rw_i), .reg_i(bus_addr_i[3:0]), .wdata_i(bus_wdata_i),
		.rdata_o(port2_rdata), .pa_i(head_byte), .pa_o(p2_pa),
		.pb_i({sync_n, 2'b11, wps_n_i, 4'b1111}), .pb_o(p2_pb),
		.ca1_i(byte_n), .ca2_o(soe), .cb2_o(mode_o), .irq_o(port2_irq));

	assign stp_o  = p2_pb[1:0];
	assign mtr_o  = p2_pb[2];
	assign act_o  = p2_pb[3];   // led
	assign freq_o = p2_pb[6:5];

	drive_gcr_head u_gcr_head (.clk(clk), .rst_n_i(rst_n_i), .hclk_i(hclk_i), .hf_i(hf_i),
		.mode_i(mode_o), .soe_i(soe), .wbyte_i(p2_pa), .rbyte_o(head_byte),
		.sync_n_o(sync_n), .byte_n_o(byte_n), .ht_o(ht_o));

	assign irq_n_o = ~(port1_irq | port2_irq);

endmodule

//--- design/drive_pkg.sv
`include "drive_settings.svh"

package drive_pkg;

	// ------------------------------------------------------------
	// bus types
	// ------------------------------------------------------------
	typedef logic [`DRV_ADDR_W-1:0] cpu_addr_t;
	typedef logic [`DRV_DATA_W-1:0] cpu_data_t;

	// register select inside one port unit
	typedef logic [3:0] reg_idx_t;

	// drive model, 1 is the 1570
	typedef logic [1:0] drv_mode_t;

	localparam drv_mode_t MODE_1541 = 2'd0;
	localparam drv_mode_t MODE_1571 = 2'd2;

	// ------------------------------------------------------------
	// head reader sequencer
	// ------------------------------------------------------------
	typedef enum logic [1:0]
	{
		HUNT,   // waiting for a sync mark
		SYNC,   // inside the run of ones
		BYTES   // counting bits into bytes
	} gcr_state_t;

endpackage

//--- design/drive_port_unit.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

module drive_port_unit
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 ena_r_i,
	input  logic                 cs_i,
	input  logic                 rw_i,
	input  drive_pkg::reg_idx_t  reg_i,
	input  drive_pkg::cpu_data_t wdata_i,
	output drive_pkg::cpu_data_t rdata_o,
	input  drive_pkg::cpu_data_t pa_i,     // external levels
	output drive_pkg::cpu_data_t pa_o,
	input  drive_pkg::cpu_data_t pb_i,
	output drive_pkg::cpu_data_t pb_o,
	input  logic                 ca1_i,
	output logic                 ca2_o,
	output logic                 cb2_o,
	output logic                 irq_o
);
	import drive_pkg::*;

	cpu_data_t  ora_q;
	cpu_data_t  orb_q;
	cpu_data_t  ddra_q;
	cpu_data_t  ddrb_q;
	logic [6:0] ifr_q;
	logic [6:0] ier_q;
	logic [1:0] pca_q;   // [0] level, [1] drive
	logic [1:0] pcb_q;
	logic       ca1_q;
	logic       wr_en;
	logic       ca1_fall;

	assign wr_en    = ena_r_i & cs_i & ~rw_i;
	assign ca1_fall = ca1_q & ~ca1_i;

	// ------------------------------------------------------------
	// open-collector pins, undriven pins float high
	// ------------------------------------------------------------
	assign pa_o  = ora_q | ~ddra_q;
	assign pb_o  = orb_q | ~ddrb_q;
	assign ca2_o = pca_q[0] | ~pca_q[1];
	assign cb2_o = pcb_q[0] | ~pcb_q[1];
	assign irq_o = |(ifr_q & ier_q);

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ora_q  <= '0;
			orb_q  <= '0;
			ddra_q <= '0;
			ddrb_q <= '0;
			ier_q  <= '0;
			pca_q  <= '0;
			pcb_q  <= '0;
		end
		else if (wr_en)
		begin
			case (reg_i)
				`DRV_REG_ORB:  orb_q  <= wdata_i;
				`DRV_REG_ORA:  ora_q  <= wdata_i;
				`DRV_REG_DDRB: ddrb_q <= wdata_i;
				`DRV_REG_DDRA: ddra_q <= wdata_i;
				`DRV_REG_IER:  ier_q  <= wdata_i[6:0];
				`DRV_REG_PCA:  pca_q  <= wdata_i[1:0];
				`DRV_REG_PCB:  pcb_q  <= wdata_i[1:0];
				default: ;
			endcase
		end
	end

	// flags, a new ca1 edge wins over a clear in the same clk
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ifr_q <= '0;
			ca1_q <= 1'b0;
		end
		else
		begin
			ca1_q <= ca1_i;
			if (wr_en && (reg_i == `DRV_REG_IFR))
				ifr_q <= ifr_q & ~wdata_i[6:0];
			if (ca1_fall)
				ifr_q[1] <= 1'b1;
		end
	end

	// ------------------------------------------------------------
	// register read
	// ------------------------------------------------------------
	always_comb
	begin
		case (reg_i)
			`DRV_REG_ORB:  rdata_o = pb_i & pb_o;   // pin read-back
			`DRV_REG_ORA:  rdata_o = pa_i & pa_o;
			`DRV_REG_DDRB: rdata_o = ddrb_q;
			`DRV_REG_DDRA: rdata_o = ddra_q;
			`DRV_REG_IFR:  rdata_o = {irq_o, ifr_q};
			`DRV_REG_IER:  rdata_o = {1'b1, ier_q};
			`DRV_REG_PCA:  rdata_o = {6'd0, pca_q};
			`DRV_REG_PCB:  rdata_o = {6'd0, pcb_q};
			default:       rdata_o = '1;
		endcase
	end

endmodule

//--- design/drive_ram.sv
`timescale 1ns/1ps
`include "drive_settings.svh"

module drive_ram
(
	input  logic                   clk,
	input  logic                   we_i,
	input  logic [`DRV_RAM_AW-1:0] addr_i,
	input  drive_pkg::cpu_data_t   wdata_i,
	output drive_pkg::cpu_data_t   rdata_o
);
	import drive_pkg::*;

	localparam int DEPTH = 1 << `DRV_RAM_AW;

	cpu_data_t mem [DEPTH];

	// single port, read lags the address by one clk
	always_ff @(posedge clk)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
		rdata_o <= mem[addr_i];
	end

endmodule

//--- design/drive_settings.svh
`ifndef DRIVE_SETTINGS_SVH
`define DRIVE_SETTINGS_SVH

// ------------------------------------------------------------
// bus widths
// ------------------------------------------------------------
`define DRV_ADDR_W    16
`define DRV_DATA_W    8
`define DRV_RAM_AW    11    // 2 KB system ram

// port unit register offsets
`define DRV_REG_ORB   4'd0
`define DRV_REG_ORA   4'd1
`define DRV_REG_DDRB  4'd2
`define DRV_REG_DDRA  4'd3
`define DRV_REG_IFR   4'd4
`define DRV_REG_IER   4'd5
`define DRV_REG_PCA   4'd6  // ca2 control
`define DRV_REG_PCB   4'd7  // cb2 control

`define DRV_SYNC_ONES 10    // one bits in a gcr sync mark

`endif

//--- project.f
+incdir+design
design/drive_pkg.sv
design/drive_clock_ctrl.sv
design/drive_bus_decode.sv
design/drive_ram.sv
design/drive_port_unit.sv
design/drive_gcr_head.sv
design/drive_logic_top.sv
test/drive_logic_tb.sv

//--- test/drive_logic_tb.sv
`timescale 1ns/1ps

module drive_logic_tb;
	import drive_pkg::*;

	localparam int WAIT_LIMIT = 200;   // clk allowed per strobe wait

	logic        clk = 1'b0;
	logic        rst_n;
	drv_mode_t   drv_mode;
	logic [1:0]  ph2_r;
	logic [1:0]  ph2_f;
	logic [3:0]  ph_cnt;
	logic        cycle_start;
	logic        cycle_mid;
	cpu_addr_t   bus_addr;
	logic        bus_rw;
	cpu_data_t   bus_wdata;
	cpu_data_t   bus_rdata;
	logic [14:0] rom_addr;
	cpu_data_t   rom_data;
	logic        iec_atn;
	logic        iec_clk_out;
	logic        iec_data_out;
	logic        hclk;
	logic        hf;
	logic        ht;
	logic        side;
	logic        mode;
	logic [1:0]  stp;
	logic        mtr;
	logic        act;
	logic [1:0]  freq;
	logic        irq_n;
	logic [10:0] pins;
	int          seed = 32'h54e3;

	drive_logic_top UUT
	(
		.clk(clk), .rst_n_i(rst_n), .drv_mode_i(drv_mode), .ph2_r_i(ph2_r), .ph2_f_i(ph2_f),
		.cycle_start_o(cycle_start), .cycle_mid_o(cycle_mid),
		.bus_addr_i(bus_addr), .bus_rw_i(bus_rw), .bus_wdata_i(bus_wdata),
		.bus_rdata_o(bus_rdata), .rom_addr_o(rom_addr), .rom_data_i(rom_data),
		.iec_atn_i(iec_atn), .iec_clk_i(1'b1), .iec_data_i(1'b1),
		.iec_clk_o(iec_clk_out), .iec_data_o(iec_data_out), .wps_n_i(1'b1), .tr00_n_i(1'b1),
		.hclk_i(hclk), .hf_i(hf), .ht_o(ht), .side_o(side), .mode_o(mode), .stp_o(stp),
		.mtr_o(mtr), .act_o(act), .freq_o(freq), .irq_n_o(irq_n)
	);

	// rom model returns the low address byte scrambled
	assign rom_data = rom_addr[7:0] ^ 8'hA5;

	// compared against the P lines of the data file
	assign pins = {freq, side, iec_clk_out, iec_data_out, irq_n, mode, act, mtr, stp};

	always #5 clk = ~clk;

	// ------------------------------------------------------------
	// phase strobes at 2 MHz every 8 clk and 1 MHz every 16 clk
	// ------------------------------------------------------------
	always @(negedge clk)
	begin
		ph2_r  = {ph_cnt[2:0] == 3'd0, ph_cnt == 4'd0};
		ph2_f  = {ph_cnt[2:0] == 3'd4, ph_cnt == 4'd8};   // half a period later
		ph_cnt = ph_cnt + 4'd1;
	end

	task automatic give_up(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
		give_up($sformatf("ERR %0d ns: %s returned %0h, expected %0h", $time, what, got, exp));
	endtask

	// sampled 1 ns after the falling edge once strobes have settled
	task automatic wait_strobe(input bit mid);
		int n;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge clk);
			#1;
			if (mid ? cycle_mid : cycle_start)
				break;
		end
		assert (n < WAIT_LIMIT) else give_up("timeout while waiting for a bus cycle strobe");
	endtask

	task automatic bus_cycle(input logic rw, input cpu_addr_t addr, input cpu_data_t wdata,
		output cpu_data_t rdata);
		wait_strobe(1'b0);
		@(negedge clk);
		bus_addr  = addr;
		bus_rw    = rw;
		bus_wdata = wdata;
		wait_strobe(1'b1);
		rdata = bus_rdata;
		wait_strobe(1'b0);
		@(negedge clk);
		bus_rw = 1'b1;   // park on a read
	endtask

	// ------------------------------------------------------------
	// head bit source and write sampler
	// ------------------------------------------------------------
	task automatic send_bits(input int count, input logic [31:0] bits);
		int i;
		int gap;
		for (i = count - 1; i >= 0; i--)
		begin
			gap = 1 + ($random(seed) & 3);
			repeat (gap) @(negedge clk);
			hclk = 1'b1;
			hf   = bits[i];
			@(negedge clk);
			hclk = 1'b0;
		end
	endtask

	task automatic check_serial(input cpu_data_t exp);
		logic [23:0] seen;
		bit          found;
		int          i;
		int          gap;
		seen  = '0;
		found = 1'b0;
		for (i = 0; i < 24; i++)
		begin
			gap = 1 + ($random(seed) & 3);
			repeat (gap) @(negedge clk);
			seen = {seen[22:0], ht};   // bit of the current cell
			hclk = 1'b1;
			@(negedge clk);
			hclk = 1'b0;
		end
		// any 8 successive cells with the msb first
		for (i = 0; i <= 16; i++)
			if (seen[i +: 8] == exp)
				found = 1'b1;
		assert (found) else mismatch("head write bits", 32'(seen), 32'(exp));
	endtask

	task automatic count_starts(input int exp);
		int n;
		int i;
		n = 0;
		repeat (64) @(negedge clk);   // speed change settles
		for (i = 0; i < 256; i++)
		begin
			@(negedge clk);
			#1;
			if (cycle_start)
				n++;
		end
		assert ((n >= exp - 1) && (n <= exp + 1))
			else mismatch("cycle starts in 256 clk", 32'(n), 32'(exp));
	endtask

	// ------------------------------------------------------------
	// file driven bus master
	// ------------------------------------------------------------
	initial
	begin
		int          fd;
		int          fields;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		cpu_data_t   got;

		rst_n     = 1'b0;
		drv_mode  = MODE_1541;
		ph_cnt    = 4'd0;
		ph2_r     = 2'b00;
		ph2_f     = 2'b00;
		bus_addr  = '0;
		bus_rw    = 1'b1;
		bus_wdata = '0;
		iec_atn   = 1'b1;
		hclk      = 1'b0;
		hf        = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("test/drive_testdata.txt", "r");
		assert (fd != 0) else give_up("could not open test/drive_testdata.txt");
		while ($fgets(line, fd) != 0)
		begin
			fields = $sscanf(line, "%c %h %h", op, a, b);
			if (fields != 3 || op == "#")
				continue;
			case (op)
				"M":
				begin
					@(negedge clk);
					drv_mode = a[1:0];
				end
				"W": bus_cycle(1'b0, a[15:0], b[7:0], got);
				"R":
				begin
					bus_cycle(1'b1, a[15:0], 8'h00, got);
					assert (got == b[7:0])
						else mismatch($sformatf("read of %h", a[15:0]), 32'(got), b);
				end
				"A":
				begin
					@(negedge clk);
					iec_atn = a[0];
				end
				"P":
				begin
					@(negedge clk);
					#1;
					assert (pins == b[10:0]) else mismatch("pin levels", 32'(pins), b);
				end
				"H": send_bits(int'(a), b);
				"T": check_serial(b[7:0]);
				"C": count_starts(int'(b));
				default: give_up($sformatf("unknown operation %c in the data file", op));
			endcase
		end
		$fclose(fd);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- test/drive_testdata.txt
# op a b, both hex
# M mode 0, W addr data, R addr expect, A atn 0, P 0 pins, H nbits bits, T 0 byte, C 0 starts
# pins are freq[1:0] side iec_clk iec_data irq_n mode act mtr stp[1:0]
P 0    63F
W 0123 5A
R 0123 5A
R 6123 5A
R 0923 FF
R C012 B7
R C0FF 5A
M 2    0
R 0123 5A
R 6123 5A
W 6456 C3
R 0456 C3
R 2000 FF
M 0    0
W 1C02 6F
W 1C00 25
P 0    235
R 1C00 B5
W 1802 1A
W 1800 00
P 0    2F5
A 0    0
P 0    2B5
W 1800 10
P 0    2F5
A 1    0
P 0    2B5
R 1800 10
W 1800 08
P 0    275
W 1C05 02
H 00A  3FF
R 1C00 35
H 009  05A
R 1C00 B5
R 1C01 5A
R 1C04 82
P 0    255
W 1C04 02
R 1C04 00
P 0    275
W 1C03 FF
W 1C01 B4
W 1C07 02
P 0    265
T 0    B4
M 2    0
W 1803 20
W 1801 20
C 0    20
W 1801 00
C 0    10
M 0    0
C 0    10
